// File: bench/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

// expected stream model and comparison against the DUT output
module tb_checker #(
    parameter int CBUF_ADDR_W = 10,
    parameter int MAX_TRIG    = 8
) (
    input  wire                    adc_clk,
    input  wire                    reset_clk_adc,
    input  readout_pkg::buf_word_t mem [2**CBUF_ADDR_W], // same contents as the memory model
    input  wire                    out_valid,
    input  readout_pkg::out_word_t out_data,
    input  wire                    rd_trig_wait,
    input  wire                    trig_fifo_rd_en,
    input  wire                    fill_done
);
    import readout_pkg::*;

    localparam int DEPTH = 2**CBUF_ADDR_W;

    out_word_t exp_q [$];          // words still owed by the DUT
    string     test_name;
    int        test_errs    = 0;
    int        tests_run    = 0;
    int        tests_failed = 0;
    int        pop_cnt      = 0;   // trigger FIFO pops in the current test
    int        done_cnt     = 0;   // fill_done pulses in the current test
    int        cycle_budget = 100; // reset plus idle test, fills add their share
    bit        quiet        = 1'b0;

    function automatic logic [31:0] lane_total(out_word_t w);
        logic [31:0] s;
        s = '0;
        for (int l = 0; l < WORDS_PER_BURST; l++) s = s + w[l];
        return s;
    endfunction

    // reference stream of one fill, pushed onto exp_q in output order
    function automatic void build_fill(int n_trig, logic [CBUF_ADDR_W-1:0] trigs [MAX_TRIG],
                                       int nb, int fill_no);
        out_word_t   w;
        logic [31:0] sum;
        int          words;
        int          a;
        sum   = '0;
        words = 0;
        for (int t = 0; t < n_trig; t++) begin
            w    = '0;
            w[3] = {WFM_HDR_TAG, 24'(t + 1)};  // waveform number counts from 1
            w[2] = 32'(trigs[t]);
            w[1] = 32'(nb);
            w[0] = 32'(fill_no);
            exp_q.push_back(w);
            sum   = sum + lane_total(w);
            words = words + 1;
            for (int b = 0; b < nb; b++) begin
                for (int l = 0; l < WORDS_PER_BURST; l++) begin
                    a    = (int'(trigs[t]) + b * WORDS_PER_BURST + l) % DEPTH; // wraps
                    w[l] = mem[a];
                end
                exp_q.push_back(w);
                sum   = sum + lane_total(w);
                words = words + 1;
            end
            cycle_budget += 12 + 4 * nb;
        end
        w    = '0;                                 // fill header
        w[3] = {FILL_HDR_TAG, 24'(fill_no)};
        w[2] = 32'(n_trig);
        w[1] = 32'(words);
        sum  = sum + lane_total(w);
        exp_q.push_back({CHECKSUM_TAG, 24'd0, 32'd0, 32'd0, sum}); // checksum goes first
        exp_q.push_back(w);
        cycle_budget += 40;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
        pop_cnt   = 0;
        done_cnt  = 0;
        exp_q.delete();
    endtask

    task automatic set_quiet(input bit on);
        quiet = on;
    endtask

    // closes a test, pop and fill_done counts are checked here
    task automatic end_test(input int exp_pops, input int exp_dones);
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected words never came out", test_name, exp_q.size());
            test_errs++;
        end
        if (pop_cnt != exp_pops) begin
            $display("[FAIL] trig_fifo_rd_en pops expected %h got %h", exp_pops, pop_cnt);
            test_errs++;
        end
        if (done_cnt != exp_dones) begin
            $display("[FAIL] fill_done pulses expected %h got %h", exp_dones, done_cnt);
            test_errs++;
        end
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("test %0d %-24s %s (%0d errors)", tests_run, test_name,
                 (test_errs == 0) ? "ok" : "bad", test_errs);
    endtask

    task automatic print_counts();
        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
    endtask

    // outputs are registered, so the falling edge sees them settled
    always @(negedge adc_clk) begin
        if (!reset_clk_adc) begin
            if (trig_fifo_rd_en) pop_cnt++;
            if (fill_done) done_cnt++;
            if (quiet && (out_valid || rd_trig_wait || trig_fifo_rd_en)) begin
                $display("%s: output active while the readout is idle", test_name);
                test_errs++;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("%s: out_valid with no word expected", test_name);
                    test_errs++;
                end else if (out_data !== exp_q[0]) begin
                    $display("[FAIL] out_data expected %h got %h", exp_q[0], out_data);
                    test_errs++;
                    void'(exp_q.pop_front());
                end else begin
                    void'(exp_q.pop_front());
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

// 4 ns adc clock, reset held high for the first 16 rising edges
module tb_clock (
    output logic adc_clk,
    output logic reset_clk_adc
);
    initial begin
        adc_clk = 1'b0;
        forever #2 adc_clk = ~adc_clk;
    end

    initial begin
        reset_clk_adc = 1'b1;
        repeat (16) @(posedge adc_clk);
        reset_clk_adc <= 1'b0;  // released on an edge like every other input
    end

endmodule

`default_nettype wire

// File: bench/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import readout_pkg::*;

    localparam int CBUF_ADDR_W = 10;
    localparam int BURST_CNT_W = 6;
    localparam int DEPTH       = 2**CBUF_ADDR_W;
    localparam int MAX_TRIG    = 8;

    logic                   adc_clk;
    logic                   reset_clk_adc;
    logic                   cbuf_rd_en;
    logic                   cbuf_trig_en;
    logic                   trig_fifo_empty = 1'b1; // nothing queued at start
    logic [CBUF_ADDR_W-1:0] trig_fifo_addr  = '0;
    logic                   trig_fifo_rd_en;
    logic [BURST_CNT_W-1:0] num_bursts;
    logic [CBUF_ADDR_W-1:0] cbuf_rd_addr;
    buf_word_t              cbuf_rd_data    = '0;
    logic                   out_valid;
    out_word_t              out_data;
    logic                   rd_trig_wait;
    logic                   fill_done;

    buf_word_t              mem [DEPTH];          // circular buffer contents
    logic [CBUF_ADDR_W-1:0] trig_q [$];           // FWFT trigger FIFO
    logic [CBUF_ADDR_W-1:0] trig_list [MAX_TRIG]; // triggers of the next fill
    logic [31:0]            lfsr = 32'h7af6_fb46;
    int                     fill_no = 0;          // fills completed so far
    int                     cycles  = 0;

    tb_clock u_tb_clock (.adc_clk, .reset_clk_adc);

    cbuf_readout_top #(.CBUF_ADDR_W(CBUF_ADDR_W), .BURST_CNT_W(BURST_CNT_W)) u_cbuf_readout_top (
        .adc_clk, .reset_clk_adc, .cbuf_rd_en, .cbuf_trig_en, .trig_fifo_empty,
        .trig_fifo_addr, .trig_fifo_rd_en, .num_bursts, .cbuf_rd_addr, .cbuf_rd_data,
        .out_valid, .out_data, .rd_trig_wait, .fill_done
    );

    tb_checker #(.CBUF_ADDR_W(CBUF_ADDR_W), .MAX_TRIG(MAX_TRIG)) u_checker (
        .adc_clk, .reset_clk_adc, .mem, .out_valid, .out_data, .rd_trig_wait,
        .trig_fifo_rd_en, .fill_done
    );

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit taken
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // memory answers one cycle after the address
    always @(posedge adc_clk) cbuf_rd_data <= mem[cbuf_rd_addr];

    // head word visible while not empty and popped on rd_en
    always @(posedge adc_clk) begin
        if (trig_fifo_rd_en && trig_q.size() != 0) void'(trig_q.pop_front());
        trig_fifo_empty <= (trig_q.size() == 0);
        trig_fifo_addr  <= (trig_q.size() != 0) ? trig_q[0] : '0;
    end

    // stalled run ends after four times the budget of the fills registered so far
    always @(posedge adc_clk) begin
        cycles++;
        if (cycles > 4 * u_checker.cycle_budget) begin
            $display("timeout after %0d cycles, DUT stopped producing words", cycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic run_fill(input string name, input int n, input int nb);
        @(posedge adc_clk);
        u_checker.begin_test(name);
        u_checker.build_fill(n, trig_list, nb, fill_no);
        @(negedge adc_clk);
        for (int i = 0; i < n; i++) trig_q.push_back(trig_list[i]);
        @(posedge adc_clk);
        num_bursts   <= BURST_CNT_W'(nb);
        cbuf_rd_en   <= 1'b1;
        cbuf_trig_en <= 1'b1;
        // all waveforms read once the FIFO is drained and the sequencer parks again
        do @(negedge adc_clk); while (!(trig_q.size() == 0 && rd_trig_wait));
        @(posedge adc_clk);
        cbuf_rd_en   <= 1'b0;   // dropped together so no second fill starts
        cbuf_trig_en <= 1'b0;
        do @(negedge adc_clk); while (!fill_done);
        repeat (4) @(posedge adc_clk);
        u_checker.end_test(n, 1);
        fill_no++;
    endtask

    initial begin
        cbuf_rd_en   = 1'b0;
        cbuf_trig_en = 1'b0;
        num_bursts   = BURST_CNT_W'(1);
        for (int a = 0; a < DEPTH; a++) mem[a] = take_bits(32);
        @(negedge reset_clk_adc);

        @(posedge adc_clk);
        u_checker.begin_test("idle after reset");
        u_checker.set_quiet(1'b1);
        repeat (20) @(posedge adc_clk);
        u_checker.set_quiet(1'b0);
        u_checker.end_test(0, 0);

        trig_list[0] = 10'd100;
        run_fill("one trigger one burst", 1, 1);

        trig_list[0] = 10'd1020;  // runs past the buffer end
        trig_list[1] = 10'd37;
        trig_list[2] = 10'd1023;
        run_fill("three triggers wrap", 3, 3);

        run_fill("no trigger", 0, 2);

        for (int f = 0; f < 4; f++) begin
            int n;
            int nb;
            nb = int'(take_bits(3)) + 1;
            n  = int'(take_bits(2)) % 3 + 1;
            for (int i = 0; i < n; i++) trig_list[i] = CBUF_ADDR_W'(take_bits(CBUF_ADDR_W));
            run_fill($sformatf("random fill %0d", f), n, nb);
        end

        u_checker.print_counts();
        if (u_checker.tests_failed == 0 && u_checker.tests_run == 8) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
verilog/readout_pkg.sv
verilog/readout_sequencer.sv
verilog/burst_assembler.sv
verilog/fill_counters.sv
verilog/frame_builder.sv
verilog/cbuf_readout_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the readout testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f files.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$LOG"
if grep -q "Result: PASSED" "$LOG"; then
    exit 0
fi
exit 1

// File: verilog/burst_assembler.sv
`timescale 1ns/1ps
`default_nettype none

// circular-buffer read address and four-word packing
module burst_assembler #(
    parameter int CBUF_ADDR_W = 10
) (
    input  wire                    adc_clk,
    input  wire                    reset_clk_adc,
    input  wire  [CBUF_ADDR_W-1:0] trig_fifo_addr, // start of the waveform in the buffer
    input  wire                    rd_addr_init,
    input  wire                    rd_addr_inc,
    input  wire                    latch_word,
    input  readout_pkg::buf_word_t cbuf_rd_data,   // one cycle behind cbuf_rd_addr
    output logic [CBUF_ADDR_W-1:0] cbuf_rd_addr,
    output readout_pkg::out_word_t data_word
);
    import readout_pkg::*;

    // power-of-two depth, so the increment wraps on its own
    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            cbuf_rd_addr <= '0;
        end else if (rd_addr_init) begin
            cbuf_rd_addr <= trig_fifo_addr;
        end else if (rd_addr_inc) begin
            cbuf_rd_addr <= cbuf_rd_addr + 1'b1;
        end
    end

    // new word enters lane 3 and older words move down
    // after four latches the first word read sits in lane 0
    always_ff @(posedge adc_clk) begin
        if (latch_word) begin
            data_word <= {cbuf_rd_data, data_word[WORDS_PER_BURST-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: verilog/cbuf_readout_top.sv
`timescale 1ns/1ps
`default_nettype none

// circular-buffer waveform readout, buffer words in, 128-bit stream words out
module cbuf_readout_top #(
    parameter int CBUF_ADDR_W = 10,
    parameter int BURST_CNT_W = 6
) (
    input  wire                    adc_clk,
    input  wire                    reset_clk_adc,
    input  wire                    cbuf_rd_en,
    input  wire                    cbuf_trig_en,
    input  wire                    trig_fifo_empty,
    input  wire  [CBUF_ADDR_W-1:0] trig_fifo_addr,
    output logic                   trig_fifo_rd_en,
    input  wire  [BURST_CNT_W-1:0] num_bursts,
    output logic [CBUF_ADDR_W-1:0] cbuf_rd_addr,
    input  readout_pkg::buf_word_t cbuf_rd_data,
    output logic                   out_valid,
    output readout_pkg::out_word_t out_data,
    output logic                   rd_trig_wait,
    output logic                   fill_done
);
    import readout_pkg::*;

    // sequencer strobes
    logic fill_init, wfm_init, rd_addr_init, rd_addr_inc, latch_word, burst_dec;
    logic sel_wfm_hdr, sel_data, sel_fill_hdr, sel_checksum;
    logic word_valid_now, word_valid_late, fill_end;

    logic                   burst_last;
    logic                   word_valid_count;
    out_word_t              data_word;
    logic [COUNT_W-1:0]     wfm_count;
    logic [COUNT_W-1:0]     fill_number;
    logic [COUNT_W-1:0]     word_count;
    logic [CBUF_ADDR_W-1:0] wfm_trig_addr;

    readout_sequencer u_readout_sequencer (
        .adc_clk, .reset_clk_adc, .cbuf_rd_en, .cbuf_trig_en, .trig_fifo_empty,
        .burst_last, .rd_trig_wait, .trig_fifo_rd_en, .fill_init, .wfm_init,
        .rd_addr_init, .rd_addr_inc, .latch_word, .burst_dec, .sel_wfm_hdr,
        .sel_data, .sel_fill_hdr, .sel_checksum, .word_valid_now,
        .word_valid_late, .fill_end, .fill_done
    );

    burst_assembler #(.CBUF_ADDR_W(CBUF_ADDR_W)) u_burst_assembler (
        .adc_clk, .reset_clk_adc, .trig_fifo_addr, .rd_addr_init, .rd_addr_inc,
        .latch_word, .cbuf_rd_data, .cbuf_rd_addr, .data_word
    );

    fill_counters #(.CBUF_ADDR_W(CBUF_ADDR_W), .BURST_CNT_W(BURST_CNT_W)) u_fill_counters (
        .adc_clk, .reset_clk_adc, .num_bursts, .fill_init, .wfm_init, .burst_dec,
        .word_valid_count, .fill_done, .trig_fifo_addr, .burst_last, .wfm_count,
        .fill_number, .word_count, .wfm_trig_addr
    );

    frame_builder #(.CBUF_ADDR_W(CBUF_ADDR_W), .BURST_CNT_W(BURST_CNT_W)) u_frame_builder (
        .adc_clk, .reset_clk_adc, .fill_init, .sel_wfm_hdr, .sel_data, .sel_fill_hdr,
        .sel_checksum, .word_valid_now, .word_valid_late, .fill_end, .data_word,
        .wfm_count, .fill_number, .word_count, .num_bursts, .wfm_trig_addr,
        .out_valid, .out_data, .word_valid_count
    );

endmodule

`default_nettype wire

// File: verilog/fill_counters.sv
`timescale 1ns/1ps
`default_nettype none

// burst countdown plus waveform, fill and output word counts
module fill_counters #(
    parameter int CBUF_ADDR_W = 10,
    parameter int BURST_CNT_W = 6
) (
    input  wire                              adc_clk,
    input  wire                              reset_clk_adc,
    input  wire  [BURST_CNT_W-1:0]           num_bursts,  // held during the fill
    input  wire                              fill_init,
    input  wire                              wfm_init,
    input  wire                              burst_dec,
    input  wire                              word_valid_count, // one per emitted word
    input  wire                              fill_done,
    input  wire  [CBUF_ADDR_W-1:0]           trig_fifo_addr,
    output logic                             burst_last,
    output logic [readout_pkg::COUNT_W-1:0]  wfm_count,
    output logic [readout_pkg::COUNT_W-1:0]  fill_number,
    output logic [readout_pkg::COUNT_W-1:0]  word_count,
    output logic [CBUF_ADDR_W-1:0]           wfm_trig_addr
);
    import readout_pkg::*;

    logic [BURST_CNT_W-1:0] burst_cnt; // bursts still to run, including the current one

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            burst_cnt   <= '0;
            wfm_count   <= '0;
            fill_number <= '0;
            word_count  <= '0;
        end else begin
            if (wfm_init) burst_cnt <= num_bursts;
            else if (burst_dec) burst_cnt <= burst_cnt - 1'b1; // dropped at the end of LOOP4

            if (fill_init) wfm_count <= '0;
            else if (wfm_init) wfm_count <= wfm_count + 1'b1; // first waveform is number 1

            if (fill_init) word_count <= '0;
            else if (word_valid_count) word_count <= word_count + 1'b1;

            if (fill_done) fill_number <= fill_number + 1'b1; // first fill is 0
        end
    end

    // trigger address for the waveform header, taken as the FIFO pops
    always_ff @(posedge adc_clk) begin
        if (wfm_init) wfm_trig_addr <= trig_fifo_addr;
    end

    assign burst_last = (burst_cnt == BURST_CNT_W'(1)); // checked in LOOP4

endmodule

`default_nettype wire

// File: verilog/frame_builder.sv
`timescale 1ns/1ps
`default_nettype none

// output word select, checksum and output register
module frame_builder #(
    parameter int CBUF_ADDR_W = 10,
    parameter int BURST_CNT_W = 6
) (
    input  wire                              adc_clk,
    input  wire                              reset_clk_adc,
    input  wire                              fill_init,
    input  wire                              sel_wfm_hdr,
    input  wire                              sel_data,
    input  wire                              sel_fill_hdr,
    input  wire                              sel_checksum,
    input  wire                              word_valid_now,
    input  wire                              word_valid_late,
    input  wire                              fill_end,    // fold fill header into checksum
    input  readout_pkg::out_word_t           data_word,
    input  wire  [readout_pkg::COUNT_W-1:0]  wfm_count,
    input  wire  [readout_pkg::COUNT_W-1:0]  fill_number,
    input  wire  [readout_pkg::COUNT_W-1:0]  word_count,
    input  wire  [BURST_CNT_W-1:0]           num_bursts,
    input  wire  [CBUF_ADDR_W-1:0]           wfm_trig_addr,
    output logic                             out_valid,
    output readout_pkg::out_word_t           out_data,
    output logic                             word_valid_count
);
    import readout_pkg::*;

    out_word_t  word_mux;    // word picked by the active select
    buf_word_t  lane_sum;    // four lanes of word_mux added
    buf_word_t  checksum;
    logic       late_d1;     // late valid, memory stage
    logic       late_d2;     // late valid, latch stage, lines up with a full data_word
    logic       sel_any;
    logic       csum_add;

    always_comb begin
        word_mux = '0;
        if (sel_wfm_hdr) begin
            word_mux[3] = {WFM_HDR_TAG, wfm_count};
            word_mux[2] = BUF_W'(wfm_trig_addr);
            word_mux[1] = BUF_W'(num_bursts);
            word_mux[0] = BUF_W'(fill_number);
        end else if (sel_data) begin
            word_mux = data_word;
        end else if (sel_checksum) begin
            word_mux[3] = {CHECKSUM_TAG, {COUNT_W{1'b0}}};
            word_mux[0] = checksum;
        end else if (sel_fill_hdr) begin
            word_mux[3] = {FILL_HDR_TAG, fill_number};
            word_mux[2] = BUF_W'(wfm_count);
            word_mux[1] = BUF_W'(word_count); // checksum not counted yet
        end
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < WORDS_PER_BURST; i++) begin
            lane_sum = lane_sum + word_mux[i];
        end
    end

    assign sel_any = sel_wfm_hdr | sel_data | sel_checksum | sel_fill_hdr;
    // headers and data as they go out, fill header once before the checksum
    assign csum_add = (word_valid_now & sel_wfm_hdr) | late_d2 | fill_end;

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            late_d1   <= 1'b0;
            late_d2   <= 1'b0;
            out_valid <= 1'b0;
            checksum  <= '0;
        end else begin
            late_d1   <= word_valid_late;
            late_d2   <= late_d1;
            out_valid <= word_valid_now | late_d2; // third stage of the late path
            if (fill_init) checksum <= '0;
            else if (csum_add) checksum <= checksum + lane_sum; // wraps mod 2^32
        end
    end

    // holds between selects, so a header chosen early is still there at its valid
    always_ff @(posedge adc_clk) begin
        if (sel_any) out_data <= word_mux;
    end

    assign word_valid_count = out_valid; // every emitted word bumps the fill word count

endmodule

`default_nettype wire

// File: verilog/readout_pkg.sv
`default_nettype none

// shared widths, word types, header tags and sequencer state indices
package readout_pkg;

    localparam int BUF_W           = 32; // one circular-buffer word, two 12-bit samples
    localparam int WORDS_PER_BURST = 4;  // buffer words packed into one stream word
    localparam int TAG_W           = 8;  // header tag sits in the top byte of lane 3
    localparam int COUNT_W         = 24; // waveform, fill and word counts

    typedef logic [BUF_W-1:0] buf_word_t;
    // lane 0 is the low 32 bits of the stream word
    typedef logic [WORDS_PER_BURST-1:0][BUF_W-1:0] out_word_t;

    localparam logic [TAG_W-1:0] WFM_HDR_TAG  = 8'hc1; // waveform header
    localparam logic [TAG_W-1:0] CHECKSUM_TAG = 8'hc5; // checksum word
    localparam logic [TAG_W-1:0] FILL_HDR_TAG = 8'hcf; // fill header

    // index of each bit in the one-hot state vector
    typedef enum logic [4:0] {
        IDLE       = 5'd0,
        FILL_INIT  = 5'd1,
        TRIG_WAIT  = 5'd2,
        WFM_INIT1  = 5'd3,
        WFM_INIT2  = 5'd4,
        WFM_INIT3  = 5'd5,
        LOOP1      = 5'd6,
        LOOP2      = 5'd7,
        LOOP3      = 5'd8,
        LOOP4      = 5'd9,
        WFM_DONE1  = 5'd10,
        WFM_DONE2  = 5'd11,
        NO_TRIGGER = 5'd12,
        FILL_DONE1 = 5'd13,
        FILL_DONE2 = 5'd14,
        FILL_DONE3 = 5'd15,
        FILL_DONE4 = 5'd16,
        DONE       = 5'd17
    } state_idx_t;

    localparam int NUM_STATES = int'(DONE) + 1; // width of the one-hot vector

endpackage

`default_nettype wire

// File: verilog/readout_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// one-hot fill / waveform / burst sequencer
// every strobe is registered from the next state, so it is high while its state is occupied
module readout_sequencer (
    input  wire  adc_clk,
    input  wire  reset_clk_adc,
    input  wire  cbuf_rd_en,       // readout enabled, a rising level starts a fill
    input  wire  cbuf_trig_en,     // triggers accepted, negation ends the fill
    input  wire  trig_fifo_empty,  // FWFT trigger FIFO has nothing pending
    input  wire  burst_last,       // the burst in flight is the last of the waveform
    output logic rd_trig_wait,     // parked in TRIG_WAIT
    output logic trig_fifo_rd_en,  // pop the trigger address
    output logic fill_init,
    output logic wfm_init,
    output logic rd_addr_init,
    output logic rd_addr_inc,
    output logic latch_word,
    output logic burst_dec,
    output logic sel_wfm_hdr,
    output logic sel_data,
    output logic sel_fill_hdr,
    output logic sel_checksum,
    output logic word_valid_now,   // selected word goes out on the next cycle
    output logic word_valid_late,  // data word goes out after the latch pipeline
    output logic fill_end,         // fold the fill header into the checksum
    output logic fill_done
);
    import readout_pkg::*;

    logic [NUM_STATES-1:0] cs;  // current state, one bit per state
    logic [NUM_STATES-1:0] ns;  // next state
    logic                  got_trig; // at least one waveform in this fill
    logic                  ns_loop;  // next state is one of LOOP1..4

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            cs       <= '0;
            cs[IDLE] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = '0;
        case (1'b1)
            cs[IDLE]: begin
                if (cbuf_rd_en) ns[FILL_INIT] = 1'b1;
                else ns[IDLE] = 1'b1;
            end
            cs[FILL_INIT]:  ns[TRIG_WAIT] = 1'b1;
            cs[TRIG_WAIT]: begin
                // a pending trigger always wins over the end of the fill
                if (!trig_fifo_empty) begin
                    ns[WFM_INIT1] = 1'b1;
                end else if (!cbuf_trig_en) begin
                    if (got_trig) ns[FILL_DONE1] = 1'b1;
                    else ns[NO_TRIGGER] = 1'b1; // empty fill, still closes cleanly
                end else begin
                    ns[TRIG_WAIT] = 1'b1;
                end
            end
            cs[WFM_INIT1]:  ns[WFM_INIT2] = 1'b1;
            cs[WFM_INIT2]:  ns[WFM_INIT3] = 1'b1;
            cs[WFM_INIT3]:  ns[LOOP1] = 1'b1;  // spacer, address still settling
            cs[LOOP1]:      ns[LOOP2] = 1'b1;
            cs[LOOP2]:      ns[LOOP3] = 1'b1;
            cs[LOOP3]:      ns[LOOP4] = 1'b1;
            cs[LOOP4]: begin
                if (burst_last) ns[WFM_DONE1] = 1'b1;
                else ns[LOOP1] = 1'b1;   // another four buffer words
            end
            cs[WFM_DONE1]:  ns[WFM_DONE2] = 1'b1;
            cs[WFM_DONE2]:  ns[TRIG_WAIT] = 1'b1;
            cs[NO_TRIGGER]: ns[FILL_DONE1] = 1'b1;
            cs[FILL_DONE1]: ns[FILL_DONE2] = 1'b1;
            cs[FILL_DONE2]: ns[FILL_DONE3] = 1'b1;
            cs[FILL_DONE3]: ns[FILL_DONE4] = 1'b1;
            cs[FILL_DONE4]: ns[DONE] = 1'b1;
            cs[DONE]:       ns[IDLE] = 1'b1;
            default:        ns[IDLE] = 1'b1; // lost one-hot, fall back to idle
        endcase
    end

    assign ns_loop = ns[LOOP1] | ns[LOOP2] | ns[LOOP3] | ns[LOOP4];

    // cleared at fill start, set by the first waveform
    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) got_trig <= 1'b0;
        else if (ns[FILL_INIT]) got_trig <= 1'b0;
        else if (ns[WFM_INIT1]) got_trig <= 1'b1;
    end

    always_ff @(posedge adc_clk) begin
        if (reset_clk_adc) begin
            rd_trig_wait    <= 1'b0;
            trig_fifo_rd_en <= 1'b0;
            fill_init       <= 1'b0;
            wfm_init        <= 1'b0;
            rd_addr_init    <= 1'b0;
            rd_addr_inc     <= 1'b0;
            latch_word      <= 1'b0;
            burst_dec       <= 1'b0;
            sel_wfm_hdr     <= 1'b0;
            sel_data        <= 1'b0;
            sel_fill_hdr    <= 1'b0;
            sel_checksum    <= 1'b0;
            word_valid_now  <= 1'b0;
            word_valid_late <= 1'b0;
            fill_end        <= 1'b0;
            fill_done       <= 1'b0;
        end else begin
            rd_trig_wait    <= ns[TRIG_WAIT];
            fill_init       <= ns[FILL_INIT];  // clear checksum and per-fill counts
            trig_fifo_rd_en <= ns[WFM_INIT1];  // head address is consumed here
            wfm_init        <= ns[WFM_INIT1];
            rd_addr_init    <= ns[WFM_INIT1];
            sel_wfm_hdr     <= ns[WFM_INIT2];
            // address steps in LOOP1..4, memory answers one cycle later
            rd_addr_inc     <= ns_loop;
            // latch runs one state behind the address, WFM_DONE1 takes the last word
            latch_word      <= ns_loop | ns[WFM_DONE1];
            sel_data        <= ns_loop | ns[WFM_DONE1] | ns[WFM_DONE2];
            burst_dec       <= ns[LOOP4];
            word_valid_late <= ns[LOOP4];
            fill_end        <= ns[FILL_DONE1];
            sel_checksum    <= ns[FILL_DONE2];
            sel_fill_hdr    <= ns[FILL_DONE1] | ns[FILL_DONE3]; // once for checksum, once out
            word_valid_now  <= ns[WFM_INIT2] | ns[FILL_DONE2] | ns[FILL_DONE3];
            fill_done       <= ns[DONE];
        end
    end

endmodule

`default_nettype wire
